/* logic/trace_pkg.sv */
//////////////////////////////
// shared widths, RV32I opcodes and the trace record types
// every tracer module refers to these by scoped name
//////////////////////////////

package trace_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;

  //////////////////////////////
  // major opcodes
  //////////////////////////////
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_fence  = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

  typedef enum logic [3:0] {
    cls_nop,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_op_imm,
    cls_op,
    cls_fence,
    cls_system,
    cls_invalid
  } instr_class_e;

  // decode stage view of the core
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            id_valid;
    logic            is_decoding;
    logic            pipe_flush;
    logic            mret;
    logic            uret;
    logic            dret;
    logic            ecall;
    logic            ebreak;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
  } id_port_t;

  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
  } reg_wr_t;

  typedef struct packed {
    logic            req;
    logic            gnt;
    logic            we;
    logic [xlen-1:0] addr;
  } mem_req_t;

  // execute stage, register write and data bus
  typedef struct packed {
    logic     valid;
    reg_wr_t  wr;
    mem_req_t mem;
  } ex_port_t;

  typedef struct packed {
    logic    valid;
    reg_wr_t wr;
  } wb_port_t;

  // one retired instruction
  typedef struct packed {
    logic [xlen-1:0]       cycle;
    logic [xlen-1:0]       seq;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    instr_class_e          cls;
    logic [reg_addr_w-1:0] rd_addr;
    logic                  writes_rd;
    logic [xlen-1:0]       rd_value;
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
    logic                  mem_valid;
    logic                  mem_we;
    logic [xlen-1:0]       mem_addr;
  } trace_rec_t;

endpackage

/* logic/instr_classifier.sv */
//////////////////////////////
// combinational RV32I decode of the instruction in decode
// gives the class and which registers the instruction uses
//////////////////////////////

module instr_classifier (
  input  logic [trace_pkg::xlen-1:0] instr,
  output trace_pkg::instr_class_e    cls,
  output logic                       writes_rd,
  output logic                       reads_rs1,
  output logic                       reads_rs2
);

  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [trace_pkg::reg_addr_w-1:0] rd;
  logic                            is_32bit;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rd       = instr[11:7];
  // compressed encodings have the low two bits not both set
  assign is_32bit = (instr[1:0] == 2'b11);

  always_comb begin
    cls       = trace_pkg::cls_invalid;
    writes_rd = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;

    case (opcode)
      trace_pkg::opc_lui: begin
        cls       = trace_pkg::cls_lui;
        writes_rd = 1'b1;
      end
      trace_pkg::opc_auipc: begin
        cls       = trace_pkg::cls_auipc;
        writes_rd = 1'b1;
      end
      trace_pkg::opc_jal: begin
        cls       = trace_pkg::cls_jal;
        writes_rd = 1'b1;
      end
      trace_pkg::opc_jalr: begin
        cls       = trace_pkg::cls_jalr;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      trace_pkg::opc_branch: begin
        cls       = trace_pkg::cls_branch;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      trace_pkg::opc_load: begin
        // no ld, and no widths 110 or 111 in RV32I
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
          cls       = trace_pkg::cls_load;
          writes_rd = 1'b1;
          reads_rs1 = 1'b1;
        end
      end
      trace_pkg::opc_store: begin
        if (funct3 < 3'd3) begin
          cls       = trace_pkg::cls_store;
          reads_rs1 = 1'b1;
          reads_rs2 = 1'b1;
        end
      end
      trace_pkg::opc_op_imm: begin
        cls       = trace_pkg::cls_op_imm;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      trace_pkg::opc_op: begin
        cls       = trace_pkg::cls_op;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      trace_pkg::opc_fence: begin
        cls = trace_pkg::cls_fence;
      end
      trace_pkg::opc_system: begin
        cls       = trace_pkg::cls_system;
        // csr ops write rd, only the register forms read rs1
        writes_rd = (funct3 != 3'b000);
        reads_rs1 = !funct3[2] && (funct3 != 3'b000);
      end
      default: begin
        cls = trace_pkg::cls_invalid;
      end
    endcase

    if (!is_32bit) begin
      cls       = trace_pkg::cls_invalid;
      writes_rd = 1'b0;
      reads_rs1 = 1'b0;
      reads_rs2 = 1'b0;
    end else if (instr == trace_pkg::nop_word) begin
      // nop alias uses no registers
      cls       = trace_pkg::cls_nop;
      writes_rd = 1'b0;
      reads_rs1 = 1'b0;
      reads_rs2 = 1'b0;
    end

    // x0 is never a real destination
    if (rd == '0) begin
      writes_rd = 1'b0;
    end
  end

endmodule

/* logic/cycle_counter.sv */
//////////////////////////////
// free-running cycle and retired-instruction counts
//////////////////////////////

module cycle_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       retire,
  output logic [trace_pkg::xlen-1:0] cycle,
  output logic [trace_pkg::xlen-1:0] instret
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle   <= '0;
      instret <= '0;
    end else begin
      cycle <= cycle + 1'b1;
      if (retire) begin
        instret <= instret + 1'b1;
      end
    end
  end

endmodule

/* logic/trace_ctrl_fsm.sv */
//////////////////////////////
// tracing on/off control, gates capture at decode
// and derives the stage advance strobes
//////////////////////////////

module trace_ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable,
  input  trace_pkg::id_port_t id,
  input  logic                ex_valid,
  input  logic                wb_bypass,
  input  logic                wb_valid,
  input  logic                ex_busy,
  input  logic                wb_busy,
  output logic                capture,
  output logic                ex_advance,
  output logic                wb_advance
);

  typedef enum logic [1:0] {
    st_off,
    st_tracing,
    st_draining
  } state_e;

  state_e state;
  state_e state_next;
  logic   decode_event;

  //////////////////////////////
  // state register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_off;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_off: begin
        if (fetch_enable) begin
          state_next = st_tracing;
        end
      end
      st_tracing: begin
        if (!fetch_enable) begin
          state_next = st_draining;
        end
      end
      st_draining: begin
        if (fetch_enable) begin
          state_next = st_tracing;
        end else if (!ex_busy && !wb_busy) begin
          state_next = st_off;
        end
      end
      default: begin
        state_next = st_off;
      end
    endcase
  end

  //////////////////////////////
  // strobes
  //////////////////////////////
  // anything leaving decode, including flushes and traps
  assign decode_event = id.is_decoding &&
                        (id.id_valid || id.pipe_flush || id.mret || id.uret ||
                         id.dret || id.ecall || id.ebreak);

  assign capture = (state == st_tracing) && decode_event;

  // branches skip writeback, so bypass also ends execute
  assign ex_advance = ex_valid || wb_bypass;
  assign wb_advance = wb_valid;

endmodule

/* logic/trace_pipeline.sv */
//////////////////////////////
// execute and writeback record slots with value merging
// drives the retired record and the sticky overflow flag
//////////////////////////////

module trace_pipeline (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            capture,
  input  logic                            ex_advance,
  input  logic                            wb_advance,
  input  trace_pkg::id_port_t             id,
  input  trace_pkg::instr_class_e         cls,
  input  logic                            writes_rd,
  input  logic                            reads_rs1,
  input  logic                            reads_rs2,
  input  logic [trace_pkg::xlen-1:0]      cycle,
  input  logic [trace_pkg::xlen-1:0]      instret,
  input  trace_pkg::reg_wr_t              ex_wr,
  input  trace_pkg::reg_wr_t              wb_wr,
  input  trace_pkg::mem_req_t             mem,
  output logic                            ex_busy,
  output logic                            wb_busy,
  output logic                            retire,
  output logic                            trace_valid,
  output logic                            trace_overflow,
  output trace_pkg::trace_rec_t           trace
);

  trace_pkg::trace_rec_t cap_rec;
  trace_pkg::trace_rec_t ex_rec;
  trace_pkg::trace_rec_t ex_upd;
  trace_pkg::trace_rec_t wb_rec;
  trace_pkg::trace_rec_t wb_upd;
  logic                  ex_occ;
  logic                  wb_occ;
  logic                  ex_moving;
  logic                  ex_hold;
  logic                  wb_retiring;

  //////////////////////////////
  // record build and merge
  //////////////////////////////
  always_comb begin
    cap_rec           = '0;
    cap_rec.cycle     = cycle;
    cap_rec.pc        = id.pc;
    cap_rec.instr     = id.instr;
    cap_rec.cls       = cls;
    cap_rec.rd_addr   = id.instr[11:7];
    cap_rec.writes_rd = writes_rd;
    cap_rec.rs1_value = reads_rs1 ? id.rs1_value : '0;
    cap_rec.rs2_value = reads_rs2 ? id.rs2_value : '0;
  end

  always_comb begin
    ex_upd = ex_rec;
    if (ex_wr.we && ex_wr.addr == ex_rec.rd_addr) begin
      ex_upd.rd_value = ex_wr.wdata;
    end
    // only the first granted access is kept
    if (!ex_rec.mem_valid && mem.req && mem.gnt) begin
      ex_upd.mem_valid = 1'b1;
      ex_upd.mem_we    = mem.we;
      ex_upd.mem_addr  = mem.addr;
    end
  end

  always_comb begin
    wb_upd = wb_rec;
    if (wb_wr.we && wb_wr.addr == wb_rec.rd_addr) begin
      wb_upd.rd_value = wb_wr.wdata;
    end
  end

  assign ex_moving   = ex_occ && ex_advance;
  assign ex_hold     = ex_occ && !ex_advance;
  assign wb_retiring = wb_occ && wb_advance;

  assign ex_busy = ex_occ;
  assign wb_busy = wb_occ;
  assign retire  = wb_retiring;

  //////////////////////////////
  // slot occupancy and flags
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_occ         <= 1'b0;
      wb_occ         <= 1'b0;
      trace_valid    <= 1'b0;
      trace_overflow <= 1'b0;
    end else begin
      trace_valid <= wb_retiring;

      if (capture) begin
        if (ex_hold) begin
          trace_overflow <= 1'b1;
        end else begin
          ex_occ <= 1'b1;
        end
      end else if (ex_moving) begin
        ex_occ <= 1'b0;
      end

      if (ex_moving) begin
        if (wb_occ && !wb_retiring) begin
          trace_overflow <= 1'b1;
        end else begin
          wb_occ <= 1'b1;
        end
      end else if (wb_retiring) begin
        wb_occ <= 1'b0;
      end
    end
  end

  // record payloads
  always_ff @(posedge clk) begin
    if (capture && !ex_hold) begin
      ex_rec <= cap_rec;
    end else if (ex_occ) begin
      ex_rec <= ex_upd;
    end

    if (ex_moving && (!wb_occ || wb_retiring)) begin
      wb_rec <= ex_upd;
    end else if (wb_occ) begin
      wb_rec <= wb_upd;
    end

    if (wb_retiring) begin
      trace     <= wb_upd;
      trace.seq <= instret;
    end
  end

endmodule

/* logic/instr_tracer.sv */
//////////////////////////////
// instruction trace unit top, watches decode, execute and
// writeback and emits one record per retired instruction
//////////////////////////////

module instr_tracer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable,
  input  trace_pkg::id_port_t   id,
  input  trace_pkg::ex_port_t   ex,
  input  logic                  wb_bypass,
  input  trace_pkg::wb_port_t   wb,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace,
  output logic                  trace_overflow
);

  logic                       capture;
  logic                       ex_advance;
  logic                       wb_advance;
  logic                       ex_busy;
  logic                       wb_busy;
  logic                       retire;
  logic [trace_pkg::xlen-1:0] cycle;
  logic [trace_pkg::xlen-1:0] instret;
  trace_pkg::instr_class_e    cls;
  logic                       writes_rd;
  logic                       reads_rs1;
  logic                       reads_rs2;

  trace_ctrl_fsm trace_ctrl_fsm_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_enable (fetch_enable),
    .id           (id),
    .ex_valid     (ex.valid),
    .wb_bypass    (wb_bypass),
    .wb_valid     (wb.valid),
    .ex_busy      (ex_busy),
    .wb_busy      (wb_busy),
    .capture      (capture),
    .ex_advance   (ex_advance),
    .wb_advance   (wb_advance)
  );

  cycle_counter cycle_counter_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .retire  (retire),
    .cycle   (cycle),
    .instret (instret)
  );

  instr_classifier instr_classifier_inst (
    .instr     (id.instr),
    .cls       (cls),
    .writes_rd (writes_rd),
    .reads_rs1 (reads_rs1),
    .reads_rs2 (reads_rs2)
  );

  trace_pipeline trace_pipeline_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .capture        (capture),
    .ex_advance     (ex_advance),
    .wb_advance     (wb_advance),
    .id             (id),
    .cls            (cls),
    .writes_rd      (writes_rd),
    .reads_rs1      (reads_rs1),
    .reads_rs2      (reads_rs2),
    .cycle          (cycle),
    .instret        (instret),
    .ex_wr          (ex.wr),
    .wb_wr          (wb.wr),
    .mem            (ex.mem),
    .ex_busy        (ex_busy),
    .wb_busy        (wb_busy),
    .retire         (retire),
    .trace_valid    (trace_valid),
    .trace_overflow (trace_overflow),
    .trace          (trace)
  );

endmodule

/* test/tracer_tests.svh */
//////////////////////////////
// directed tests and expected-record helpers
// included inside the tracer testbench top
//////////////////////////////

//////////////////////////////
// bookkeeping and checks
//////////////////////////////
task automatic open_test(input string name);
  test_name         = name;
  test_start_errors = error_count;
  test_total++;
endtask

task automatic report_test();
  if (error_count == test_start_errors) begin
    $display("test %0d %s: ok", test_total, test_name);
  end else begin
    failed_tests++;
    $display("test %0d %s: FAILED with %0d errors", test_total, test_name,
             error_count - test_start_errors);
  end
endtask

task automatic check_field(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  assert (got === exp) else begin
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    error_count++;
  end
endtask

//////////////////////////////
// stimulus
//////////////////////////////
task automatic apply_reset();
  rst_n        = 1'b0;
  fetch_enable = 1'b0;
  id           = '0;
  ex           = '0;
  wb           = '0;
  wb_bypass    = 1'b0;
  repeat (8) @(negedge clk);
  rst_n = 1'b1;
endtask

// state moves to tracing on the next edge
task automatic enable_tracing();
  fetch_enable = 1'b1;
  @(negedge clk);
endtask

task automatic decode_instr(input logic [31:0] pc, input logic [31:0] instr,
                            input logic [31:0] rs1, input logic [31:0] rs2,
                            output logic [31:0] stamp);
  id             = '0;
  id.pc          = pc;
  id.instr       = instr;
  id.id_valid    = 1'b1;
  id.is_decoding = 1'b1;
  id.rs1_value   = rs1;
  id.rs2_value   = rs2;
  // counter value seen at the capture edge
  stamp = clk_count;
  @(negedge clk);
  id = '0;
endtask

function automatic trace_pkg::reg_wr_t reg_write(input logic we, input logic [4:0] addr,
                                                 input logic [31:0] data);
  trace_pkg::reg_wr_t wr;
  wr.we    = we;
  wr.addr  = addr;
  wr.wdata = data;
  return wr;
endfunction

function automatic trace_pkg::mem_req_t mem_access(input logic req, input logic gnt,
                                                   input logic we, input logic [31:0] addr);
  trace_pkg::mem_req_t mem;
  mem.req  = req;
  mem.gnt  = gnt;
  mem.we   = we;
  mem.addr = addr;
  return mem;
endfunction

task automatic drive_execute(input logic valid, input logic bypass,
                             input trace_pkg::reg_wr_t wr, input trace_pkg::mem_req_t mem);
  ex.valid  = valid;
  ex.wr     = wr;
  ex.mem    = mem;
  wb_bypass = bypass;
endtask

task automatic drive_writeback(input logic valid, input trace_pkg::reg_wr_t wr);
  wb.valid = valid;
  wb.wr    = wr;
endtask

//////////////////////////////
// expected records
//////////////////////////////
// fresh record as captured, no writes and no memory access yet
function automatic trace_pkg::trace_rec_t base_record(
    input logic [31:0] stamp, input logic [31:0] seq, input logic [31:0] pc,
    input logic [31:0] instr, input trace_pkg::instr_class_e cls,
    input logic writes_rd, input logic [31:0] rs1, input logic [31:0] rs2);
  trace_pkg::trace_rec_t rec;
  rec           = '0;
  rec.cycle     = stamp;
  rec.seq       = seq;
  rec.pc        = pc;
  rec.instr     = instr;
  rec.cls       = cls;
  rec.rd_addr   = instr[11:7];
  rec.writes_rd = writes_rd;
  rec.rs1_value = rs1;
  rec.rs2_value = rs2;
  return rec;
endfunction

task automatic expect_record(input trace_pkg::trace_rec_t exp);
  logic seen;
  seen = 1'b0;
  for (int i = 0; i < 10 && !seen; i++) begin
    if (trace_valid) begin
      seen = 1'b1;
    end else begin
      @(negedge clk);
    end
  end
  assert (seen) else begin
    $display("no trace record appeared within 10 cycles at %0t ns", $time);
    error_count++;
  end
  if (seen) begin
    check_field("trace.cycle", trace.cycle, exp.cycle);
    check_field("trace.seq", trace.seq, exp.seq);
    check_field("trace.pc", trace.pc, exp.pc);
    check_field("trace.instr", trace.instr, exp.instr);
    check_field("trace.cls", trace.cls, exp.cls);
    check_field("trace.rd_addr", trace.rd_addr, exp.rd_addr);
    check_field("trace.writes_rd", trace.writes_rd, exp.writes_rd);
    check_field("trace.rd_value", trace.rd_value, exp.rd_value);
    check_field("trace.rs1_value", trace.rs1_value, exp.rs1_value);
    check_field("trace.rs2_value", trace.rs2_value, exp.rs2_value);
    check_field("trace.mem_valid", trace.mem_valid, exp.mem_valid);
    check_field("trace.mem_we", trace.mem_we, exp.mem_we);
    check_field("trace.mem_addr", trace.mem_addr, exp.mem_addr);
  end
endtask

task automatic expect_quiet(input int cycles);
  repeat (cycles) begin
    @(negedge clk);
    check_field("trace_valid", trace_valid, 32'd0);
  end
endtask

// one instruction through execute and writeback with no writes
task automatic trace_single(input logic [31:0] instr, input trace_pkg::instr_class_e cls,
                            input logic wr, input logic r1, input logic r2,
                            input logic [31:0] seq);
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic [31:0] pc;
  logic [31:0] stamp;
  rs1 = $random(seed);
  rs2 = $random(seed);
  pc  = 32'h0000_1000 + (seq << 2);
  decode_instr(pc, instr, rs1, rs2, stamp);
  drive_execute(1'b1, 1'b0, '0, '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  @(negedge clk);
  drive_writeback(1'b0, '0);
  expect_record(base_record(stamp, seq, pc, instr, cls, wr,
                            r1 ? rs1 : 32'd0, r2 ? rs2 : 32'd0));
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic check_classification();
  open_test("classification and register use");
  apply_reset();
  enable_tracing();
  trace_single(32'h00000013, trace_pkg::cls_nop, 1'b0, 1'b0, 1'b0, 32'd0);
  trace_single(32'h123452B7, trace_pkg::cls_lui, 1'b1, 1'b0, 1'b0, 32'd1);
  trace_single(32'h00001317, trace_pkg::cls_auipc, 1'b1, 1'b0, 1'b0, 32'd2);
  trace_single(32'h008000EF, trace_pkg::cls_jal, 1'b1, 1'b0, 1'b0, 32'd3);
  // jalr with x0 as destination
  trace_single(32'h00008067, trace_pkg::cls_jalr, 1'b0, 1'b1, 1'b0, 32'd4);
  trace_single(32'h00208463, trace_pkg::cls_branch, 1'b0, 1'b1, 1'b1, 32'd5);
  trace_single(32'h00412383, trace_pkg::cls_load, 1'b1, 1'b1, 1'b0, 32'd6);
  trace_single(32'h00413383, trace_pkg::cls_invalid, 1'b0, 1'b0, 1'b0, 32'd7);
  trace_single(32'h00312423, trace_pkg::cls_store, 1'b0, 1'b1, 1'b1, 32'd8);
  trace_single(32'h00313423, trace_pkg::cls_invalid, 1'b0, 1'b0, 1'b0, 32'd9);
  trace_single(32'h00500513, trace_pkg::cls_op_imm, 1'b1, 1'b1, 1'b0, 32'd10);
  trace_single(32'h00D605B3, trace_pkg::cls_op, 1'b1, 1'b1, 1'b1, 32'd11);
  trace_single(32'h0FF0000F, trace_pkg::cls_fence, 1'b0, 1'b0, 1'b0, 32'd12);
  trace_single(32'h00000073, trace_pkg::cls_system, 1'b0, 1'b0, 1'b0, 32'd13);
  trace_single(32'h340312F3, trace_pkg::cls_system, 1'b1, 1'b1, 1'b0, 32'd14);
  trace_single(32'h3401D2F3, trace_pkg::cls_system, 1'b1, 1'b0, 1'b0, 32'd15);
  // compressed encoding and an unknown opcode
  trace_single(32'h00004501, trace_pkg::cls_invalid, 1'b0, 1'b0, 1'b0, 32'd16);
  trace_single(32'h0000007F, trace_pkg::cls_invalid, 1'b0, 1'b0, 1'b0, 32'd17);
  report_test();
endtask

task automatic merge_writeback_values();
  logic [31:0]           stamp;
  logic [31:0]           ex_val;
  logic [31:0]           wb_val;
  trace_pkg::trace_rec_t exp;
  open_test("writeback merge");
  apply_reset();
  enable_tracing();
  ex_val = $random(seed);
  wb_val = $random(seed);
  // add x11, x12, x13
  decode_instr(32'h200, 32'h00D605B3, 32'h11, 32'h22, stamp);
  drive_execute(1'b1, 1'b0, reg_write(1'b1, 5'd11, ex_val), '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b0, reg_write(1'b1, 5'd11, wb_val));
  @(negedge clk);
  // x12 is not the destination
  drive_writeback(1'b1, reg_write(1'b1, 5'd12, ~wb_val));
  @(negedge clk);
  drive_writeback(1'b0, '0);
  exp = base_record(stamp, 32'd0, 32'h200, 32'h00D605B3, trace_pkg::cls_op, 1'b1,
                    32'h11, 32'h22);
  exp.rd_value = wb_val;
  expect_record(exp);
  // execute value survives non-matching writes in both stages
  decode_instr(32'h204, 32'h00D605B3, 32'h33, 32'h44, stamp);
  drive_execute(1'b0, 1'b0, reg_write(1'b1, 5'd11, ex_val), '0);
  @(negedge clk);
  drive_execute(1'b1, 1'b0, reg_write(1'b1, 5'd13, ~ex_val), '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, reg_write(1'b1, 5'd3, wb_val));
  @(negedge clk);
  drive_writeback(1'b0, '0);
  exp = base_record(stamp, 32'd1, 32'h204, 32'h00D605B3, trace_pkg::cls_op, 1'b1,
                    32'h33, 32'h44);
  exp.rd_value = ex_val;
  expect_record(exp);
  report_test();
endtask

task automatic log_memory_and_bypass();
  logic [31:0]           stamp;
  logic [31:0]           addr;
  trace_pkg::trace_rec_t exp;
  open_test("memory logging and bypass");
  apply_reset();
  enable_tracing();
  addr = $random(seed);
  // sw x3, 8(x2)
  decode_instr(32'h300, 32'h00312423, 32'h1000, 32'hCAFE, stamp);
  drive_execute(1'b0, 1'b0, '0, mem_access(1'b1, 1'b0, 1'b1, ~addr));
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, mem_access(1'b1, 1'b1, 1'b1, addr));
  @(negedge clk);
  // second grant is not the first access
  drive_execute(1'b1, 1'b0, '0, mem_access(1'b1, 1'b1, 1'b0, addr + 32'h40));
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  @(negedge clk);
  drive_writeback(1'b0, '0);
  exp = base_record(stamp, 32'd0, 32'h300, 32'h00312423, trace_pkg::cls_store, 1'b0,
                    32'h1000, 32'hCAFE);
  exp.mem_valid = 1'b1;
  exp.mem_we    = 1'b1;
  exp.mem_addr  = addr;
  expect_record(exp);
  @(negedge clk);
  check_field("trace_valid", trace_valid, 32'd0);
  // beq x1, x2, 8 leaves execute through the bypass
  decode_instr(32'h304, 32'h00208463, 32'h5, 32'h6, stamp);
  drive_execute(1'b0, 1'b1, '0, '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  @(negedge clk);
  drive_writeback(1'b0, '0);
  expect_record(base_record(stamp, 32'd1, 32'h304, 32'h00208463, trace_pkg::cls_branch,
                            1'b0, 32'h5, 32'h6));
  report_test();
endtask

task automatic retire_in_order();
  logic [31:0]           stamp_a;
  logic [31:0]           stamp_b;
  logic [31:0]           val_a;
  logic [31:0]           val_b;
  trace_pkg::trace_rec_t exp;
  open_test("in-order retirement");
  apply_reset();
  enable_tracing();
  val_a = $random(seed);
  val_b = $random(seed);
  // addi x10 then add x11 with both in flight
  decode_instr(32'h400, 32'h00500513, 32'h55, 32'h66, stamp_a);
  drive_execute(1'b1, 1'b0, reg_write(1'b1, 5'd10, ~val_a), '0);
  decode_instr(32'h404, 32'h00D605B3, 32'h77, 32'h88, stamp_b);
  drive_execute(1'b1, 1'b0, reg_write(1'b1, 5'd11, val_b), '0);
  drive_writeback(1'b1, reg_write(1'b1, 5'd10, val_a));
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  exp = base_record(stamp_a, 32'd0, 32'h400, 32'h00500513, trace_pkg::cls_op_imm, 1'b1,
                    32'h55, 32'h0);
  exp.rd_value = val_a;
  expect_record(exp);
  @(negedge clk);
  drive_writeback(1'b0, '0);
  exp = base_record(stamp_b, 32'd1, 32'h404, 32'h00D605B3, trace_pkg::cls_op, 1'b1,
                    32'h77, 32'h88);
  exp.rd_value = val_b;
  expect_record(exp);
  // moving into a retiring writeback slot is not an overflow
  check_field("trace_overflow", trace_overflow, 32'd0);
  report_test();
endtask

task automatic gate_with_fetch_enable();
  logic [31:0] stamp;
  open_test("state machine gating");
  apply_reset();
  // tracing off so decode activity never reaches the slots
  id.instr       = 32'h00500513;
  id.id_valid    = 1'b1;
  id.is_decoding = 1'b1;
  drive_execute(1'b1, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  expect_quiet(4);
  id = '0;
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b0, '0);
  enable_tracing();
  // ecall leaving decode without id_valid
  id.pc          = 32'h500;
  id.instr       = 32'h00000073;
  id.ecall       = 1'b1;
  id.is_decoding = 1'b1;
  id.rs1_value   = 32'hDEAD;
  stamp          = clk_count;
  @(negedge clk);
  id           = '0;
  fetch_enable = 1'b0;
  drive_execute(1'b1, 1'b0, '0, '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  // decode event while draining
  id.instr       = 32'h00D605B3;
  id.id_valid    = 1'b1;
  id.is_decoding = 1'b1;
  drive_writeback(1'b1, '0);
  @(negedge clk);
  id = '0;
  drive_writeback(1'b0, '0);
  expect_record(base_record(stamp, 32'd0, 32'h500, 32'h00000073, trace_pkg::cls_system,
                            1'b0, 32'h0, 32'h0));
  id.instr       = 32'h00D605B3;
  id.id_valid    = 1'b1;
  id.is_decoding = 1'b1;
  drive_execute(1'b1, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  expect_quiet(5);
  id = '0;
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b0, '0);
  report_test();
endtask

task automatic detect_overflow();
  logic [31:0] stamp;
  logic [31:0] dropped_stamp;
  open_test("overflow");
  apply_reset();
  check_field("trace_overflow", trace_overflow, 32'd0);
  enable_tracing();
  decode_instr(32'h600, 32'h00500513, 32'h7, 32'h9, stamp);
  // execute held, so this capture is dropped
  decode_instr(32'h604, 32'h00D605B3, 32'h1, 32'h2, dropped_stamp);
  check_field("trace_overflow", trace_overflow, 32'd1);
  drive_execute(1'b1, 1'b0, '0, '0);
  @(negedge clk);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  @(negedge clk);
  drive_writeback(1'b0, '0);
  expect_record(base_record(stamp, 32'd0, 32'h600, 32'h00500513, trace_pkg::cls_op_imm,
                            1'b1, 32'h7, 32'h0));
  drive_execute(1'b1, 1'b0, '0, '0);
  drive_writeback(1'b1, '0);
  expect_quiet(4);
  drive_execute(1'b0, 1'b0, '0, '0);
  drive_writeback(1'b0, '0);
  check_field("trace_overflow", trace_overflow, 32'd1);
  report_test();
endtask

/* test/instr_tracer_tb.sv */
//////////////////////////////
// testbench top for the instruction tracer
// runs the directed tests from the included file and prints a summary
//////////////////////////////

module instr_tracer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period    = 40;
  // rough cycle cost of each directed test, reset included
  localparam int test_cycles   = 90 + 20 + 25 + 20 + 25 + 20;
  localparam int margin_cycles = 100;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_enable;
  trace_pkg::id_port_t   id;
  trace_pkg::ex_port_t   ex;
  logic                  wb_bypass;
  trace_pkg::wb_port_t   wb;
  logic                  trace_valid;
  trace_pkg::trace_rec_t trace;
  logic                  trace_overflow;

  int          seed;
  int          error_count;
  int          failed_tests;
  int          test_total;
  int          test_start_errors;
  string       test_name;
  logic [31:0] clk_count;

  instr_tracer instr_tracer_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable   (fetch_enable),
    .id             (id),
    .ex             (ex),
    .wb_bypass      (wb_bypass),
    .wb             (wb),
    .trace_valid    (trace_valid),
    .trace          (trace),
    .trace_overflow (trace_overflow)
  );

  always #(clk_period / 2) clk = ~clk;

  // rising edges seen since reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_count <= '0;
    end else begin
      clk_count <= clk_count + 32'd1;
    end
  end

  `include "tracer_tests.svh"

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    id           = '0;
    ex           = '0;
    wb_bypass    = 1'b0;
    wb           = '0;
    seed         = 34428;
    error_count  = 0;
    failed_tests = 0;
    test_total   = 0;

    check_classification();
    merge_writeback_values();
    log_memory_and_bypass();
    retire_in_order();
    gate_with_fetch_enable();
    detect_overflow();

    $display("%0d tests run, %0d failed, %0d check errors",
             test_total, failed_tests, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((test_cycles + margin_cycles) * clk_period);
    $display("watchdog expired, the tests did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

/* files.f */
logic/trace_pkg.sv
logic/instr_classifier.sv
logic/cycle_counter.sv
logic/trace_ctrl_fsm.sv
logic/trace_pipeline.sv
logic/instr_tracer.sv
+incdir+test
test/instr_tracer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the tracer testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module instr_tracer_tb -o instr_tracer_sim &&
  ./obj_dir/instr_tracer_sim > sim.log 2>&1 ; cat sim.log 2>/dev/null

grep -qs 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
